//--- tb/yuv_to_rgb_input.txt
# I y0 y1 u v   one input pair in hex, two lumas then the even chroma
# E word        one expected output word in hex, three per pair
# Two rows of four pairs, row 1 clips and ends grey, row 2 has steeply rising chroma
I FF FF 80 FF
E FFAE
E FFFF
E E2FF
I 00 00 80 80
E 0000
E 0000
E 0000
I 10 EB 80 80
E 0000
E 00FF
E F6FE
I 80 80 80 80
E 8282
E 8282
E 8282
I 00 3C 00 20
E 006D
E 0000
E A200
I 5A 78 50 40
E 009C
E 0079
E 7C68
I 96 B4 A0 C0
E FF5B
E DCFF
E 55FF
I D2 F0 F0 E0
E FF67
E FFFF
E 8FFF

//--- all.f
design/color_pkg.sv
design/stream_pkg.sv
design/chroma_window.sv
design/chroma_upsampler.sv
design/csc_lane.sv
design/rgb_packer.sv
design/yuv_to_rgb_top.sv
tb/tb_yuv_to_rgb.sv

//--- tb/tb_yuv_to_rgb.sv
`timescale 1ns/1ps

module tb_yuv_to_rgb;
	import stream_pkg::*;

	localparam int CLK_HALF = 2;
	localparam int RESET_CYCLES = 3;
	localparam int IDLE_CYCLES = 20;
	// Same stream twice, once free-running and once under back-pressure
	localparam int N_PASSES = 2;
	localparam int WORDS_PER_PAIR = 3;
	localparam int ROW_WORDS = WORDS_PER_PAIR * ROW_PAIRS;

	logic Clock_50;
	logic resetn;
	yuv_pair_t in_pair;
	logic in_valid;
	logic in_ready;
	rgb_word_t out_word;
	logic out_valid;
	logic out_ready;

	// Stimulus and expected words from the data file
	yuv_pair_t pair_q [$];
	rgb_word_t exp_q [$];
	// One entry per received word, set when it matched
	bit word_ok [$];

	int rx_count = 0;
	int total_words = 0;
	int error_count = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int cycle_count = 0;
	int cycle_limit = 0;
	// Input ready checks after reset and at each row end
	int ready_checks = 0;
	int ready_wrong = 0;
	bit random_mode = 1'b0;
	bit mon_ok;

	yuv_to_rgb_top u_dut (
		.Clock_50(Clock_50),
		.resetn(resetn),
		.in_pair(in_pair),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.out_word(out_word),
		.out_valid(out_valid),
		.out_ready(out_ready)
	);

	initial begin
		Clock_50 = 1'b0;
		forever #(CLK_HALF) Clock_50 = ~Clock_50;
	end

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
			input string what, output bit ok);
		ok = (actual === expected);
		if (!ok) begin
			error_count++;
			$display("Error at %0t ns: %s is 0x%0h, expected 0x%0h",
				$time, what, actual, expected);
		end
	endtask

	// Compares in_ready and keeps the tally for the flow-control report
	task automatic check_in_ready(input logic expected, input string what);
		bit ok;
		check_value(in_ready, expected, what, ok);
		ready_checks++;
		if (!ok)
			ready_wrong++;
	endtask

	// Lines tagged I hold y0 y1 u v, lines tagged E one word, # starts a comment
	task automatic load_file();
		int fd;
		int n;
		bit done;
		logic [7:0] tag;
		logic [8*128-1:0] line;
		logic [7:0] y0, y1, u, v;
		logic [15:0] w;
		fd = $fopen("tb/yuv_to_rgb_input.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the data file tb/yuv_to_rgb_input.txt");
			error_count++;
			return;
		end
		done = 1'b0;
		while (!done) begin
			n = $fscanf(fd, " %c", tag);
			if (n != 1) begin
				done = 1'b1;
			end else if (tag == "#") begin
				n = $fgets(line, fd);
			end else if (tag == "I") begin
				n = $fscanf(fd, " %h %h %h %h", y0, y1, u, v);
				if (n != 4) begin
					$display("Data file has an input line with missing fields");
					error_count++;
				end
				pair_q.push_back({y0, y1, u, v});
			end else if (tag == "E") begin
				n = $fscanf(fd, " %h", w);
				if (n != 1) begin
					$display("Data file has an expected line without a word");
					error_count++;
				end
				exp_q.push_back(w);
			end else begin
				$display("Data file has a line with an unknown tag");
				error_count++;
				done = 1'b1;
			end
		end
		$fclose(fd);
	endtask

	// Called on a falling edge, returns on the falling edge after the transfer
	task automatic send_pair(input yuv_pair_t p, input int gap);
		in_valid = 1'b0;
		repeat (gap) @(negedge Clock_50);
		in_pair = p;
		in_valid = 1'b1;
		@(posedge Clock_50);
		while (!in_ready) @(posedge Clock_50);
		@(negedge Clock_50);
	endtask

	// Sends every pair, then waits on the rising edge until target words arrived
	task automatic run_pass(input bit with_gaps, input int target);
		int gap;
		@(negedge Clock_50);
		for (int i = 0; i < pair_q.size(); i++) begin
			gap = with_gaps ? int'($urandom % 3) : 0;
			send_pair(pair_q[i], gap);
			// Row tail is flushed without taking input
			if ((i % ROW_PAIRS) == ROW_PAIRS - 1)
				check_in_ready(1'b0, "in_ready after the last pair of a row");
		end
		in_valid = 1'b0;
		while (rx_count < target) @(posedge Clock_50);
	endtask

	// Missing words count as wrong
	function automatic int count_wrong(input int first, input int last);
		int n;
		n = 0;
		for (int i = first; i <= last; i++)
			if (i >= word_ok.size() || !word_ok[i])
				n++;
		return n;
	endfunction

	task automatic report_test(input int num, input string name, input int wrong,
			input int total);
		tests_run++;
		if (wrong == 0) begin
			$display("Test %0d %s: PASS (%0d checks)", num, name, total);
		end else begin
			tests_failed++;
			$display("Test %0d %s: FAIL (%0d of %0d checks wrong)", num, name, wrong, total);
		end
	endtask

	// Output ready is random only during the back-pressure pass
	always @(negedge Clock_50) begin
		if (random_mode)
			out_ready = (($urandom % 2) == 1);
		else
			out_ready = 1'b1;
	end

	// Word transfers on a rising edge with valid and ready high
	always @(posedge Clock_50) begin
		if (resetn && out_valid && out_ready) begin
			if (exp_q.size() == 0 || rx_count >= total_words) begin
				$display("Unexpected word 0x%h at %0t ns beyond the expected stream",
					out_word, $time);
				error_count++;
			end else begin
				check_value(out_word, exp_q[rx_count % exp_q.size()],
					$sformatf("word %0d", rx_count), mon_ok);
				word_ok.push_back(mon_ok);
			end
			rx_count++;
		end
	end

	initial begin : watchdog
		do begin
			@(posedge Clock_50);
			cycle_count++;
		end while (cycle_count < cycle_limit);
		$display("Timeout after %0d cycles with %0d of %0d words received",
			cycle_count, rx_count, total_words);
		$display("Some tests failed");
		$finish;
	end

	initial begin
		int errors_before;
		bit ok;
		void'($urandom(87427));
		in_pair = '0;
		in_valid = 1'b0;
		out_ready = 1'b0;
		resetn = 1'b0;
		load_file();
		total_words = exp_q.size() * N_PASSES;
		cycle_limit = 20 * total_words + 100;
		repeat (RESET_CYCLES) @(posedge Clock_50);
		@(negedge Clock_50);
		resetn = 1'b1;
		check_in_ready(1'b1, "in_ready after reset");

		// Free-running pass covers the content checks
		run_pass(1'b0, exp_q.size());
		report_test(1, "packing order", count_wrong(0, exp_q.size() - 1), exp_q.size());
		report_test(2, "flat grey", count_wrong(ROW_WORDS - 3, ROW_WORDS - 1), 3);
		report_test(3, "clipping", count_wrong(0, ROW_WORDS - 4), ROW_WORDS - 3);
		report_test(4, "edge replication", count_wrong(ROW_WORDS, 2 * ROW_WORDS - 1),
			ROW_WORDS);

		// Mode changes on the rising edge, read on the falling edge
		random_mode = 1'b1;
		run_pass(1'b1, total_words);
		random_mode = 1'b0;
		report_test(5, "back-pressure",
			count_wrong(exp_q.size(), total_words - 1) + ready_wrong,
			total_words - exp_q.size() + ready_checks);

		// Nothing may follow the last word
		errors_before = error_count;
		ok = 1'b1;
		for (int i = 0; i < IDLE_CYCLES && ok; i++) begin
			@(posedge Clock_50);
			check_value(out_valid, 1'b0, "out_valid after the last word", ok);
		end
		check_value(rx_count, total_words, "received word count", ok);
		check_value(exp_q.size(), WORDS_PER_PAIR * pair_q.size(), "expected words per pair",
			ok);
		report_test(6, "completeness", error_count - errors_before, IDLE_CYCLES + 2);

		$display("Summary: %0d tests, %0d failed, %0d words received, %0d errors",
			tests_run, tests_failed, rx_count, error_count);
		if (tests_failed == 0 && error_count == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

//--- design/yuv_to_rgb_top.sv
`timescale 1ns/1ps

module yuv_to_rgb_top (
	input logic Clock_50,
	input logic resetn,
	input stream_pkg::yuv_pair_t in_pair,
	input logic in_valid,
	output logic in_ready,
	output stream_pkg::rgb_word_t out_word,
	output logic out_valid,
	input logic out_ready
);
	import stream_pkg::*;

	// Windowed pairs
	window_item_t win_item;
	logic win_valid;
	logic win_ready;

	// One pixel per lane
	yuv_pixel_t pix [N_LANES];
	logic pix_valid;
	logic pix_ready;

	// Converted pixels
	rgb_pixel_t rgb [N_LANES];
	logic rgb_valid;
	logic rgb_ready;

	// Lanes run in lockstep, lane 0 speaks for all
	logic lane_in_ready [N_LANES];
	logic lane_out_valid [N_LANES];

	assign pix_ready = lane_in_ready[0];
	assign rgb_valid = lane_out_valid[0];

	chroma_window u_window (
		.Clock_50(Clock_50),
		.resetn(resetn),
		.in_pair(in_pair),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.win_item(win_item),
		.win_valid(win_valid),
		.win_ready(win_ready)
	);

	chroma_upsampler u_upsampler (
		.Clock_50(Clock_50),
		.resetn(resetn),
		.win_item(win_item),
		.win_valid(win_valid),
		.win_ready(win_ready),
		.pix(pix),
		.pix_valid(pix_valid),
		.pix_ready(pix_ready)
	);

	for (genvar i = 0; i < N_LANES; i++) begin : g_lane
		csc_lane u_lane (
			.Clock_50(Clock_50),
			.resetn(resetn),
			.pix_in(pix[i]),
			.in_valid(pix_valid),
			.in_ready(lane_in_ready[i]),
			.rgb_out(rgb[i]),
			.out_valid(lane_out_valid[i]),
			.out_ready(rgb_ready)
		);
	end

	rgb_packer u_packer (
		.Clock_50(Clock_50),
		.resetn(resetn),
		.rgb_in(rgb),
		.in_valid(rgb_valid),
		.in_ready(rgb_ready),
		.out_word(out_word),
		.out_valid(out_valid),
		.out_ready(out_ready)
	);

endmodule

//--- design/rgb_packer.sv
`timescale 1ns/1ps

module rgb_packer (
	input logic Clock_50,
	input logic resetn,
	input stream_pkg::rgb_pixel_t rgb_in [stream_pkg::N_LANES],
	input logic in_valid,
	output logic in_ready,
	output stream_pkg::rgb_word_t out_word,
	output logic out_valid,
	input logic out_ready
);
	import stream_pkg::*;

	// Pair being serialised
	rgb_pixel_t hold [N_LANES];
	logic full;
	// Word of the pair currently offered
	logic [1:0] word_cnt;
	logic last_word;

	assign last_word = out_ready && (word_cnt == 2'd2);
	assign in_ready = !full || last_word;
	assign out_valid = full;

	// Byte pairing, first colour in the high byte
	always_comb begin
		case (word_cnt)
			2'd0: out_word = {hold[0].r, hold[0].g};
			2'd1: out_word = {hold[0].b, hold[1].r};
			default: out_word = {hold[1].g, hold[1].b};
		endcase
	end

	always_ff @(posedge Clock_50 or negedge resetn) begin
		if (!resetn) begin
			full <= 1'b0;
			word_cnt <= 2'd0;
		end else if (in_valid && in_ready) begin
			// New pair, possibly in the cycle the old one finishes
			full <= 1'b1;
			word_cnt <= 2'd0;
		end else if (full && out_ready) begin
			if (word_cnt == 2'd2) begin
				full <= 1'b0;
				word_cnt <= 2'd0;
			end else begin
				word_cnt <= word_cnt + 2'd1;
			end
		end
	end

	always_ff @(posedge Clock_50) begin
		if (in_valid && in_ready)
			hold <= rgb_in;
	end

endmodule

//--- design/csc_lane.sv
`timescale 1ns/1ps

module csc_lane (
	input logic Clock_50,
	input logic resetn,
	input stream_pkg::yuv_pixel_t pix_in,
	input logic in_valid,
	output logic in_ready,
	output stream_pkg::rgb_pixel_t rgb_out,
	output logic out_valid,
	input logic out_ready
);
	import color_pkg::*;

	// Offset-removed inputs
	product_t yy;
	product_t uu;
	product_t vv;

	// Stage 1 products
	product_t y_term;
	product_t rv_term;
	product_t gu_term;
	product_t gv_term;
	product_t bu_term;
	logic s1_valid;
	logic s1_ready;

	// Stage 2 sums before scaling
	product_t r_sum;
	product_t g_sum;
	product_t b_sum;

	assign yy = product_t'(pix_in.y) - Y_OFFSET;
	assign uu = product_t'(pix_in.u) - C_OFFSET;
	assign vv = product_t'(pix_in.v) - C_OFFSET;

	assign s1_ready = !out_valid || out_ready;
	assign in_ready = !s1_valid || s1_ready;

	assign r_sum = y_term + rv_term;
	assign g_sum = y_term - gu_term - gv_term;
	assign b_sum = y_term + bu_term;

	always_ff @(posedge Clock_50 or negedge resetn) begin
		if (!resetn) begin
			s1_valid <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			if (in_ready)
				s1_valid <= in_valid;
			if (s1_ready)
				out_valid <= s1_valid;
		end
	end

	always_ff @(posedge Clock_50) begin
		if (in_valid && in_ready) begin
			y_term <= K_Y * yy;
			rv_term <= K_RV * vv;
			gu_term <= K_GU * uu;
			gv_term <= K_GV * vv;
			bu_term <= K_BU * uu;
		end
		// Drop the fraction, then saturate by sign and overflow
		if (s1_valid && s1_ready) begin
			rgb_out.r <= clip_pixel(r_sum >>> CSC_SHIFT);
			rgb_out.g <= clip_pixel(g_sum >>> CSC_SHIFT);
			rgb_out.b <= clip_pixel(b_sum >>> CSC_SHIFT);
		end
	end

endmodule

//--- design/chroma_upsampler.sv
`timescale 1ns/1ps

module chroma_upsampler (
	input logic Clock_50,
	input logic resetn,
	input stream_pkg::window_item_t win_item,
	input logic win_valid,
	output logic win_ready,
	output stream_pkg::yuv_pixel_t pix [stream_pkg::N_LANES],
	output logic pix_valid,
	input logic pix_ready
);
	import color_pkg::*;
	import stream_pkg::*;

	// Interpolated chroma halfway between tap[2] and tap[3]
	function automatic pixel_t fir6(input chroma_win_t w);
		product_t acc;
		acc = TAP_OUTER * (product_t'(w.tap[0]) + product_t'(w.tap[5]))
			- TAP_MID * (product_t'(w.tap[1]) + product_t'(w.tap[4]))
			+ TAP_INNER * (product_t'(w.tap[2]) + product_t'(w.tap[3]))
			+ FIR_ROUND;
		// Negative sums are possible on steep edges
		return clip_pixel(acc >>> FIR_SHIFT);
	endfunction

	logic take;

	assign win_ready = !pix_valid || pix_ready;
	assign take = win_valid && win_ready;

	always_ff @(posedge Clock_50 or negedge resetn) begin
		if (!resetn)
			pix_valid <= 1'b0;
		else if (win_ready)
			pix_valid <= win_valid;
	end

	always_ff @(posedge Clock_50) begin
		if (take) begin
			// Even pixel keeps the sampled chroma
			pix[0].y <= win_item.pair.y0;
			pix[0].u <= win_item.pair.u;
			pix[0].v <= win_item.pair.v;
			// Odd pixel gets filtered chroma
			pix[1].y <= win_item.pair.y1;
			pix[1].u <= fir6(win_item.u_win);
			pix[1].v <= fir6(win_item.v_win);
		end
	end

endmodule

//--- design/chroma_window.sv
`timescale 1ns/1ps

module chroma_window (
	input logic Clock_50,
	input logic resetn,
	input stream_pkg::yuv_pair_t in_pair,
	input logic in_valid,
	output logic in_ready,
	output stream_pkg::window_item_t win_item,
	output logic win_valid,
	input logic win_ready
);
	import color_pkg::*;
	import stream_pkg::*;

	typedef enum logic [1:0] {
		FILL,
		RUN,
		FLUSH
	} win_state_t;

	win_state_t state;
	logic [$clog2(ROW_PAIRS)-1:0] pair_cnt;
	logic [1:0] flush_left;

	// Chroma history, newest sample enters at the top tap
	chroma_win_t u_sr;
	chroma_win_t v_sr;

	// Lumas wait here until their window is complete
	pixel_t y0_dly [0:WIN_LEAD];
	pixel_t y1_dly [0:WIN_LEAD];

	logic accept;
	logic flush_step;

	// No input while the row tail is being flushed
	assign in_ready = (state != FLUSH) && (!win_valid || win_ready);
	assign accept = in_valid && in_ready;
	// Output taken with tail pairs still to emit
	assign flush_step = (state == FLUSH) && win_ready && (flush_left != 2'd0);

	// Emitted pair is the oldest in the luma line, its chroma at the window centre
	assign win_item.pair.y0 = y0_dly[0];
	assign win_item.pair.y1 = y1_dly[0];
	assign win_item.pair.u = u_sr.tap[WIN_LEAD-1];
	assign win_item.pair.v = v_sr.tap[WIN_LEAD-1];
	assign win_item.u_win = u_sr;
	assign win_item.v_win = v_sr;

	always_ff @(posedge Clock_50 or negedge resetn) begin
		if (!resetn) begin
			state <= FILL;
			pair_cnt <= '0;
			flush_left <= 2'd0;
			win_valid <= 1'b0;
		end else begin
			case (state)
				FILL, RUN: begin
					if (accept) begin
						pair_cnt <= pair_cnt + 1'b1;
						// Enough pairs ahead of the oldest one
						if (state == RUN || pair_cnt == $bits(pair_cnt)'(WIN_LEAD)) begin
							win_valid <= 1'b1;
							state <= RUN;
						end
						// Last pair of the row, emit the tail without input
						if (pair_cnt == $bits(pair_cnt)'(ROW_PAIRS - 1)) begin
							state <= FLUSH;
							flush_left <= 2'(WIN_LEAD);
							pair_cnt <= '0;
						end
					end else if (win_ready) begin
						win_valid <= 1'b0;
					end
				end
				FLUSH: begin
					if (flush_step) begin
						flush_left <= flush_left - 2'd1;
					end else if (win_ready) begin
						// Final pair of the row taken
						win_valid <= 1'b0;
						state <= FILL;
					end
				end
				default: state <= FILL;
			endcase
		end
	end

	always_ff @(posedge Clock_50) begin
		if (accept) begin
			// First pair of a row stands in for the samples before the row
			if (pair_cnt == '0) begin
				u_sr.tap <= {WIN_TAPS{in_pair.u}};
				v_sr.tap <= {WIN_TAPS{in_pair.v}};
			end else begin
				u_sr.tap <= {u_sr.tap[1:WIN_TAPS-1], in_pair.u};
				v_sr.tap <= {v_sr.tap[1:WIN_TAPS-1], in_pair.v};
			end
			for (int i = 0; i < WIN_LEAD; i++) begin
				y0_dly[i] <= y0_dly[i+1];
				y1_dly[i] <= y1_dly[i+1];
			end
			y0_dly[WIN_LEAD] <= in_pair.y0;
			y1_dly[WIN_LEAD] <= in_pair.y1;
		end else if (flush_step) begin
			// Past the row end the last sample repeats
			u_sr.tap <= {u_sr.tap[1:WIN_TAPS-1], u_sr.tap[WIN_TAPS-1]};
			v_sr.tap <= {v_sr.tap[1:WIN_TAPS-1], v_sr.tap[WIN_TAPS-1]};
			for (int i = 0; i < WIN_LEAD; i++) begin
				y0_dly[i] <= y0_dly[i+1];
				y1_dly[i] <= y1_dly[i+1];
			end
		end
	end

endmodule

//--- design/stream_pkg.sv
package stream_pkg;

	// Pairs per row, short for simulation, 160 for a full line
	localparam int ROW_PAIRS = 4;
	// One conversion lane per pixel of a pair
	localparam int N_LANES = 2;
	// Chroma samples in each filter window
	localparam int WIN_TAPS = 6;
	// Pairs that must arrive after a pair before its window is complete
	localparam int WIN_LEAD = WIN_TAPS / 2;

	// One output word holding two colour bytes
	typedef logic [15:0] rgb_word_t;

	// Two lumas and the chroma shared by the even pixel
	typedef struct packed {
		color_pkg::pixel_t y0;
		color_pkg::pixel_t y1;
		color_pkg::pixel_t u;
		color_pkg::pixel_t v;
	} yuv_pair_t;

	// Filter window, oldest sample in tap[0]
	typedef struct packed {
		color_pkg::pixel_t [0:WIN_TAPS-1] tap;
	} chroma_win_t;

	typedef struct packed {
		yuv_pair_t pair;
		chroma_win_t u_win;
		chroma_win_t v_win;
	} window_item_t;

	typedef struct packed {
		color_pkg::pixel_t y;
		color_pkg::pixel_t u;
		color_pkg::pixel_t v;
	} yuv_pixel_t;

	typedef struct packed {
		color_pkg::pixel_t r;
		color_pkg::pixel_t g;
		color_pkg::pixel_t b;
	} rgb_pixel_t;

endpackage

//--- design/color_pkg.sv
package color_pkg;

	// One 8-bit sample or colour component
	typedef logic [7:0] pixel_t;

	// Signed accumulator shared by the filter and the colour conversion
	typedef logic signed [31:0] product_t;

	// Six-tap chroma interpolation filter, symmetric about the centre
	localparam int TAP_OUTER = 21;
	localparam int TAP_MID = 52;
	localparam int TAP_INNER = 159;

	// Rounding term added before the filter normalisation shift
	localparam int FIR_ROUND = 128;
	localparam int FIR_SHIFT = 8;

	// Studio-swing offsets for luma and chroma
	localparam int Y_OFFSET = 16;
	localparam int C_OFFSET = 128;

	// Conversion coefficients, scaled by 2^16
	localparam int K_Y = 76284;
	localparam int K_RV = 104595;
	localparam int K_GU = 25624;
	localparam int K_GV = 53281;
	localparam int K_BU = 132251;
	localparam int CSC_SHIFT = 16;

	// Saturate a signed result to 0..255
	function automatic pixel_t clip_pixel(input product_t x);
		if (x[31])
			return 8'd0;
		else if (|x[30:8])
			return 8'hff;
		return x[7:0];
	endfunction

endpackage
